// ==== div_operand_prep.sv ====
// divider input step, takes operand magnitudes and records sign and zero flags
`default_nettype none
`timescale 1ns/1ps

module div_operand_prep import rv_isa_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  div_op_e op,
  input  word_t   dividend,
  input  word_t   divisor,
  div_pipe_if.src link
);

  logic  is_signed;
  logic  dvd_neg;
  logic  dvs_neg;
  word_t dvd_mag;
  word_t dvs_mag;

  // DIV and REM treat both operands as two's complement
  assign is_signed = (op == OP_DIV) || (op == OP_REM);

  assign dvd_neg = is_signed && dividend[XLEN-1];
  assign dvs_neg = is_signed && divisor[XLEN-1];

  // the most negative dividend maps onto itself, read as unsigned 2^31
  assign dvd_mag = dvd_neg ? -dividend : dividend;
  assign dvs_mag = dvs_neg ? -divisor : divisor;

  always_ff @(posedge clk) begin
    if (rst) begin
      link.valid <= 1'b0;
    end else begin
      link.valid <= in_valid;
    end
  end

  // payload follows the valid bit without a reset
  always_ff @(posedge clk) begin
    link.op       <= op;
    link.rem      <= '0;
    link.quo      <= dvd_mag;
    link.dvs      <= dvs_mag;
    // quotient is negative when the operand signs differ
    link.neg_quo  <= dvd_neg ^ dvs_neg;
    // remainder takes the sign of the dividend
    link.neg_rem  <= dvd_neg;
    link.div_zero <= (divisor == '0);
  end

endmodule : div_operand_prep

`default_nettype wire

// ==== div_pipe_if.sv ====
// stage-to-stage link of the divide pipeline, one operation per link
`default_nettype none
`timescale 1ns/1ps

interface div_pipe_if import rv_isa_pkg::*;
();

  // operation present on this link
  logic    valid;
  div_op_e op;

  // partial remainder
  word_t   rem;
  // quotient bits so far, remaining dividend bits above them
  word_t   quo;
  // divisor magnitude
  word_t   dvs;

  // sign and special-case flags for the fixup
  logic    neg_quo;
  logic    neg_rem;
  logic    div_zero;

  modport src (
    output valid, op, rem, quo, dvs, neg_quo, neg_rem, div_zero
  );

  modport dst (
    input valid, op, rem, quo, dvs, neg_quo, neg_rem, div_zero
  );

endinterface : div_pipe_if

`default_nettype wire

// ==== div_pipe_pkg.sv ====
// divider pipeline constants, stage count and request-to-result latency
`default_nettype none

package div_pipe_pkg;

  import rv_isa_pkg::*;

  // identical iteration stages between prep and fixup
  localparam int DIV_STAGES = 8;

  // quotient bits resolved in each stage
  // the full word is covered once every stage has run
  localparam int BITS_PER_STAGE = XLEN / DIV_STAGES;

  // cycles spent in operand prep and in result fixup
  localparam int PREP_CYCLES = 1;
  localparam int FIX_CYCLES = 1;

  // clock cycles from request to result
  localparam int DIV_LATENCY = PREP_CYCLES + DIV_STAGES + FIX_CYCLES;

  // a new request may enter every cycle, so this many can be in flight
  localparam int MAX_IN_FLIGHT = DIV_LATENCY;

endpackage : div_pipe_pkg

`default_nettype wire

// ==== div_result_fix.sv ====
// divider output step, applies sign and zero-divisor rules and registers result
`default_nettype none
`timescale 1ns/1ps

module div_result_fix import rv_isa_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  div_pipe_if.dst link,
  output logic    out_valid,
  output word_t   result
);

  word_t quo_fixed;
  word_t rem_fixed;
  word_t res_sel;

  // zero divisor returns all ones regardless of sign
  // signed overflow needs nothing extra, negating 2^31 gives the dividend back
  always_comb begin
    if (link.div_zero) begin
      quo_fixed = WORD_ONES;
    end else if (link.neg_quo) begin
      quo_fixed = -link.quo;
    end else begin
      quo_fixed = link.quo;
    end
  end

  // under a zero divisor rem holds the dividend magnitude
  // so restoring the sign returns the original dividend
  assign rem_fixed = link.neg_rem ? -link.rem : link.rem;

  always_comb begin
    case (link.op)
      OP_DIV, OP_DIVU: res_sel = quo_fixed;
      OP_REM, OP_REMU: res_sel = rem_fixed;
      default:         res_sel = rem_fixed;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= link.valid;
    end
  end

  always_ff @(posedge clk) begin
    result <= res_sel;
  end

endmodule : div_result_fix

`default_nettype wire

// ==== div_stage.sv ====
// one registered block of restoring-division iterations
`default_nettype none
`timescale 1ns/1ps

module div_stage import rv_isa_pkg::*, div_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  div_pipe_if.dst up,
  div_pipe_if.src down
);

  word_t         rem_next;
  word_t         quo_next;
  logic [XLEN:0] trial;
  logic [XLEN:0] dvs_ext;

  // one extra bit so the shifted remainder never overflows
  assign dvs_ext = {1'b0, up.dvs};

  // BITS_PER_STAGE iterations, each shifts one dividend bit into the remainder
  always_comb begin
    rem_next = up.rem;
    quo_next = up.quo;
    trial    = '0;
    for (int i = 0; i < BITS_PER_STAGE; i++) begin
      trial    = {rem_next, quo_next[XLEN-1]};
      quo_next = {quo_next[XLEN-2:0], 1'b0};
      // subtract only when the divisor fits
      if (trial >= dvs_ext) begin
        trial       = trial - dvs_ext;
        quo_next[0] = 1'b1;
      end
      // the remainder stays below the divisor, so the top bit is clear
      rem_next = trial[XLEN-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    down.rem      <= rem_next;
    down.quo      <= quo_next;
    // remaining fields ride along unchanged
    down.op       <= up.op;
    down.dvs      <= up.dvs;
    down.neg_quo  <= up.neg_quo;
    down.neg_rem  <= up.neg_rem;
    down.div_zero <= up.div_zero;
  end

endmodule : div_stage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the divide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_rv_div_unit \
  -Mdir obj_dir -o sim_tb \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_tb)"
echo "$out"

echo "$out" | grep -qxF '>>> PASS' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== rv_div_unit.sv ====
// pipelined rv32m divide unit, one request per cycle with fixed latency
`default_nettype none
`timescale 1ns/1ps

module rv_div_unit import rv_isa_pkg::*, div_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  div_op_e op,
  input  word_t   dividend,
  input  word_t   divisor,
  output logic    out_valid,
  output word_t   result
);

  // link 0 is written by prep, link DIV_STAGES is read by the fixup
  div_pipe_if link [DIV_STAGES+1] ();

  div_operand_prep u_prep (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op       (op),
    .dividend (dividend),
    .divisor  (divisor),
    .link     (link[0])
  );

  // each stage resolves BITS_PER_STAGE quotient bits
  for (genvar k = 0; k < DIV_STAGES; k++) begin : g_stage
    div_stage u_stage (
      .clk  (clk),
      .rst  (rst),
      .up   (link[k]),
      .down (link[k+1])
    );
  end

  div_result_fix u_fix (
    .clk       (clk),
    .rst       (rst),
    .link      (link[DIV_STAGES]),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule : rv_div_unit

`default_nettype wire

// ==== rv_isa_pkg.sv ====
// rv32 isa definitions shared by the divide unit, word type and divide opcodes
`default_nettype none

package rv_isa_pkg;

  // architectural register width
  localparam int XLEN = 32;

  // one register-sized value
  typedef logic [XLEN-1:0] word_t;

  // divide opcodes use the rv32m funct3 encoding
  // bit 0 set marks the unsigned forms
  // bit 1 set selects the remainder instead of the quotient
  typedef enum logic [2:0] {
    OP_DIV  = 3'b100,
    OP_DIVU = 3'b101,
    OP_REM  = 3'b110,
    OP_REMU = 3'b111
  } div_op_e;

  // most negative signed value, the operand of the overflow case
  localparam word_t WORD_MIN = {1'b1, {(XLEN-1){1'b0}}};

  // quotient returned for a zero divisor
  localparam word_t WORD_ONES = '1;

endpackage : rv_isa_pkg

`default_nettype wire

// ==== tb.f ====
rv_isa_pkg.sv
div_pipe_pkg.sv
div_pipe_if.sv
div_operand_prep.sv
div_stage.sv
div_result_fix.sv
rv_div_unit.sv
tb_rv_div_unit.sv

// ==== tb_rv_div_unit.sv ====
// testbench for the pipelined rv32m divide unit, directed and random checks
`default_nettype none
`timescale 1ns/1ps

module tb_rv_div_unit import rv_isa_pkg::*, div_pipe_pkg::*;
();

  // extra cycles granted beyond the nominal latency while draining
  localparam int DRAIN_MARGIN = 4;

  // cycles from the cycle a request is presented to the cycle its result shows
  localparam int EXP_LATENCY = 10;

  logic    clk = 1'b0;
  logic    rst;
  logic    in_valid;
  div_op_e op;
  word_t   dividend;
  word_t   divisor;
  logic    out_valid;
  word_t   result;

  // expected results and the cycle in which each request was presented
  word_t   exp_q[$];
  int      edge_q[$];
  int      cyc = 0;
  string   cur_test = "reset";
  int      value_errors = 0;
  int      latency_errors = 0;
  int      protocol_errors = 0;
  int      timeout_errors = 0;

  rv_div_unit DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .dividend  (dividend),
    .divisor   (divisor),
    .out_valid (out_valid),
    .result    (result)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // rv32m reference, truncating division with the zero and overflow rules
  function automatic word_t model_div(input div_op_e f_op, input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    word_t q;
    word_t r;
    logic  is_signed;
    sa = a;
    sb = b;
    is_signed = (f_op == OP_DIV) || (f_op == OP_REM);
    if (b == 32'h0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = 32'h0;
    end else if (is_signed) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
    return (f_op == OP_DIV || f_op == OP_DIVU) ? q : r;
  endfunction

  function automatic div_op_e random_op();
    case ($urandom_range(3))
      0: return OP_DIV;
      1: return OP_DIVU;
      2: return OP_REM;
      default: return OP_REMU;
    endcase
  endfunction

  // outputs are stable at the falling edge
  always @(negedge clk) begin : out_monitor
    word_t exp_val;
    int    req_cycle;
    if (out_valid !== 1'b0) begin
      assert (exp_q.size() != 0) else begin
        $display("%s: out_valid went high with no request in flight", cur_test);
        protocol_errors++;
      end
      if (exp_q.size() != 0) begin
        exp_val = exp_q.pop_front();
        req_cycle = edge_q.pop_front();
        assert (result === exp_val) else begin
          $display("[FAIL] %s: expected %h, actual %h", cur_test, exp_val, result);
          value_errors++;
        end
        // cyc already names the cycle the output is seen in
        assert (cyc - req_cycle == EXP_LATENCY) else begin
          $display("[FAIL] %s: latency expected %0d, actual %0d", cur_test,
                   EXP_LATENCY, cyc - req_cycle);
          latency_errors++;
        end
      end
    end
    // anything in flight is dropped by reset
    if (rst) begin
      exp_q.delete();
      edge_q.delete();
    end
  end

  task automatic issue(input div_op_e f_op, input word_t a, input word_t b);
    @(posedge clk);
    in_valid <= 1'b1;
    op       <= f_op;
    dividend <= a;
    divisor  <= b;
    exp_q.push_back(model_div(f_op, a, b));
    // cyc still holds the count from before this edge
    edge_q.push_back(cyc + 1);
  endtask

  task automatic drain();
    int n;
    @(posedge clk);
    in_valid <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < DIV_LATENCY + DRAIN_MARGIN) begin
      @(posedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d result(s) never arrived before the timeout", cur_test, exp_q.size());
      timeout_errors++;
      exp_q.delete();
      edge_q.delete();
    end
  endtask

  task automatic test_unsigned();
    word_t a;
    word_t b;
    cur_test = "unsigned";
    issue(OP_DIVU, 32'd100, 32'd7);
    issue(OP_REMU, 32'd100, 32'd7);
    issue(OP_DIVU, 32'hffff_ffff, 32'd3);
    issue(OP_REMU, 32'hdead_beef, 32'h0000_1234);
    issue(OP_DIVU, 32'd7, 32'd100);
    issue(OP_REMU, 32'h8000_0000, 32'hffff_ffff);
    for (int i = 0; i < 8; i++) begin
      a = $urandom();
      b = $urandom() >> $urandom_range(31);
      issue(OP_DIVU, a, b);
      issue(OP_REMU, a, b);
    end
    drain();
  endtask

  task automatic test_signed();
    word_t mag_a[3] = '{32'd7, 32'd100, 32'h7fff_ffff};
    word_t mag_b[3] = '{32'd2, 32'd7, 32'd3};
    word_t a;
    word_t b;
    cur_test = "signed";
    // every sign combination of each magnitude pair
    for (int p = 0; p < 3; p++) begin
      for (int s = 0; s < 4; s++) begin
        a = s[0] ? -mag_a[p] : mag_a[p];
        b = s[1] ? -mag_b[p] : mag_b[p];
        issue(OP_DIV, a, b);
        issue(OP_REM, a, b);
      end
    end
    issue(OP_DIV, 32'h8000_0000, 32'd2);
    issue(OP_REM, 32'h8000_0001, 32'hffff_fff0);
    drain();
  endtask

  task automatic test_div_zero();
    word_t dvd[5] = '{32'd0, 32'd5, 32'hffff_fffb, 32'h8000_0000, 32'h1234_5678};
    cur_test = "div_zero";
    for (int i = 0; i < 5; i++) begin
      issue(OP_DIV, dvd[i], 32'd0);
      issue(OP_DIVU, dvd[i], 32'd0);
      issue(OP_REM, dvd[i], 32'd0);
      issue(OP_REMU, dvd[i], 32'd0);
    end
    drain();
  endtask

  task automatic test_overflow();
    cur_test = "overflow";
    issue(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    issue(OP_REM, 32'h8000_0000, 32'hffff_ffff);
    issue(OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
    drain();
  endtask

  task automatic test_throughput();
    cur_test = "throughput";
    for (int i = 0; i < 40; i++) begin
      issue(random_op(), $urandom(), $urandom() >> $urandom_range(31));
    end
    drain();
  endtask

  task automatic test_reset();
    cur_test = "reset";
    for (int i = 0; i < 5; i++) begin
      issue(random_op(), $urandom(), $urandom_range(1, 1000));
    end
    @(posedge clk);
    in_valid <= 1'b0;
    rst      <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // the monitor flags any stale out_valid while the pipe is empty
    repeat (DIV_LATENCY + DRAIN_MARGIN) @(posedge clk);
    issue(OP_DIV, 32'hffff_ff9c, 32'd7);
    drain();
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = OP_DIV;
    dividend = '0;
    divisor  = '0;
    void'($urandom(32'he577));
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // idle pipe after reset
    repeat (4) @(posedge clk);
    test_unsigned();
    test_signed();
    test_div_zero();
    test_overflow();
    test_throughput();
    test_reset();
    $display("errors: value %0d, latency %0d, protocol %0d, timeout %0d",
             value_errors, latency_errors, protocol_errors, timeout_errors);
    if (value_errors + latency_errors + protocol_errors + timeout_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_rv_div_unit

`default_nettype wire
